// ==== Bender.yml ====
package:
  name: vga_game

sources:
  - src/vga_pkg.sv
  - src/vga_timing.sv
  - src/draw_screen_start.sv
  - src/game_ctl.sv
  - src/draw_field.sv
  - src/draw_keeper.sv
  - src/vga_game_top.sv
  - target: simulation
    files:
      - sim/vga_game_tb.sv

// ==== sim/vga_game_tb.sv ====
/*
 * Testbench for the penalty-kick display path.
 * Runs a tiny screen through a table of start, stop and keeper
 * moves and checks every output pixel against a reference model.
 */

`timescale 1ns/1ns

module vga_game_tb import vga_pkg::*; ();

  localparam int H_ACTIVE         = 50;
  localparam int H_TOTAL          = 64;
  localparam int H_SYNC_START     = 54;
  localparam int H_SYNC_END       = 58;
  localparam int V_ACTIVE         = 20;
  localparam int V_TOTAL          = 26;
  localparam int V_SYNC_START     = 22;
  localparam int V_SYNC_END       = 23;
  localparam int ST_STRIPE_WIDTH  = 2;
  localparam int ST_STRIPE_HEIGHT = 3;
  localparam int KEEPER_WIDTH     = 6;
  localparam int KEEPER_HEIGHT    = 4;
  localparam int KEEPER_Y         = 10;

  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int CLK_PERIOD   = 4;
  localparam int NUM_ROWS     = 9;

  localparam logic [1:0] ACT_IDLE  = 2'd0;
  localparam logic [1:0] ACT_START = 2'd1;
  localparam logic [1:0] ACT_STOP  = 2'd2;

  // Start screen stripes 0 to 23, left to right.
  localparam logic [0:23][11:0] STRIPE_RGB = {
    YELLOW_START, RED_START,    BLACK_START,  GREEN_START,
    WHITE_START,  RED_START,    BLUE_START,   WHITE_START,
    RED_START,    YELLOW_START, BLACK_START,  YELLOW_START,
    GREEN_START,  RED_START,    YELLOW_START, BLUE_START,
    BLACK_START,  WHITE_START,  GREEN_START,  RED_START,
    BLUE_START,   YELLOW_START, WHITE_START,  GREEN_START
  };

  typedef struct packed {
    logic [1:0]  action;
    logic        rand_x;
    logic [10:0] kx;
    logic [3:0]  frames;
    logic        mid_change;
  } row_t;

  logic        clk;
  logic        rst;
  logic        start;
  logic        stop;
  logic [10:0] keeper_x;
  vga_pixel_t  vga_out;

  row_t   rows [NUM_ROWS];
  int     error_count;
  int     kx_drive;
  logic   play_exp;
  longint watchdog_ns;

  vga_game_top #(
    .H_ACTIVE         (H_ACTIVE),
    .H_TOTAL          (H_TOTAL),
    .H_SYNC_START     (H_SYNC_START),
    .H_SYNC_END       (H_SYNC_END),
    .V_ACTIVE         (V_ACTIVE),
    .V_TOTAL          (V_TOTAL),
    .V_SYNC_START     (V_SYNC_START),
    .V_SYNC_END       (V_SYNC_END),
    .ST_STRIPE_WIDTH  (ST_STRIPE_WIDTH),
    .ST_STRIPE_HEIGHT (ST_STRIPE_HEIGHT),
    .KEEPER_WIDTH     (KEEPER_WIDTH),
    .KEEPER_HEIGHT    (KEEPER_HEIGHT),
    .KEEPER_Y         (KEEPER_Y)
  ) vga_game_top_inst (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .stop     (stop),
    .keeper_x (keeper_x),
    .vga_out  (vga_out)
  );

  always #2 clk = ~clk;

  function automatic row_t make_row(input logic [1:0] action, input logic rand_x,
                                    input int kx, input int frames, input logic mid);
    row_t row;
    row.action     = action;
    row.rand_x     = rand_x;
    row.kx         = 11'(kx);
    row.frames     = 4'(frames);
    row.mid_change = mid;
    return row;
  endfunction

  function automatic int clamp_x(input int x);
    return (x > H_ACTIVE - KEEPER_WIDTH) ? H_ACTIVE - KEEPER_WIDTH : x;
  endfunction

  // Reference pixel from the coordinate, the mode and the latched keeper column.
  function automatic vga_pixel_t expected_pixel(input int h, input int v, input logic play,
                                                input int kx);
    vga_pixel_t px;
    logic       on_goal;
    logic       in_keeper;
    on_goal = (h >= H_ACTIVE / 4 && h <= 3 * H_ACTIVE / 4 && (v == 1 || v == V_ACTIVE / 2)) ||
              (v >= 1 && v <= V_ACTIVE / 2 && (h == H_ACTIVE / 4 || h == 3 * H_ACTIVE / 4));
    in_keeper = (h >= kx) && (h < kx + KEEPER_WIDTH) &&
                (v >= KEEPER_Y) && (v < KEEPER_Y + KEEPER_HEIGHT);
    px.hcount = 11'(h);
    px.vcount = 11'(v);
    px.hsync  = (h >= H_SYNC_START) && (h < H_SYNC_END);
    px.hblnk  = (h >= H_ACTIVE);
    px.vsync  = (v >= V_SYNC_START) && (v < V_SYNC_END);
    px.vblnk  = (v >= V_ACTIVE);
    if (px.hblnk || px.vblnk) begin
      px.rgb = '0;
    end else if (play) begin
      px.rgb = in_keeper ? KEEPER_COLOUR : (on_goal ? WHITE_START : FIELD_GREEN);
    end else if (v >= ST_STRIPE_HEIGHT && v <= V_ACTIVE - ST_STRIPE_HEIGHT) begin
      px.rgb = WHITE_START;
    end else if (h / ST_STRIPE_WIDTH >= 24) begin
      px.rgb = RED_START;
    end else begin
      px.rgb = STRIPE_RGB[h / ST_STRIPE_WIDTH];
    end
    return px;
  endfunction

  task automatic check_value(input logic [39:0] got, input logic [39:0] exp,
                             input string what);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic check_pixel(input int h, input int v, input int kx);
    vga_pixel_t exp;
    exp = expected_pixel(h, v, play_exp, kx);
    check_value(vga_out.hcount, exp.hcount, "hcount");
    check_value(vga_out.vcount, exp.vcount, $sformatf("vcount at hcount %0d", h));
    check_value({vga_out.hsync, vga_out.hblnk, vga_out.vsync, vga_out.vblnk},
                {exp.hsync, exp.hblnk, exp.vsync, exp.vblnk},
                $sformatf("sync/blank flags at (%0d,%0d)", h, v));
    check_value(vga_out.rgb, exp.rgb, $sformatf("rgb at (%0d,%0d)", h, v));
  endtask

  // Leaves the current (0,0) if any, then stops on the next one.
  task automatic wait_frame_start();
    @(negedge clk);
    while (vga_out.hcount == 11'd0 && vga_out.vcount == 11'd0) @(negedge clk);
    while (!(vga_out.hcount == 11'd0 && vga_out.vcount == 11'd0)) @(negedge clk);
  endtask

  task automatic apply_row(input row_t row);
    int kx;
    kx = row.rand_x ? int'($urandom % 64) : int'(row.kx);
    @(posedge clk);
    keeper_x <= 11'(kx);
    kx_drive = kx;
    if (row.action == ACT_START) begin
      start <= 1'b1;
      play_exp = 1'b1;
    end else if (row.action == ACT_STOP) begin
      stop <= 1'b1;
      play_exp = 1'b0;
    end
    @(posedge clk);
    start <= 1'b0;
    stop  <= 1'b0;
  endtask

  // Starts at a frame start on vga_out and checks whole frames.
  task automatic observe(input int frames, input logic mid);
    int h;
    int v;
    int kx_lat;
    h = 0;
    v = 0;
    kx_lat = clamp_x(kx_drive);
    for (int n = 0; n < frames * FRAME_CYCLES; n++) begin
      if (n > 0) @(negedge clk);
      check_pixel(h, v, kx_lat);
      if (mid && n == FRAME_CYCLES / 2) begin
        kx_drive = (kx_drive + 9 + int'($urandom % 20)) % 64;
        @(posedge clk);
        keeper_x <= 11'(kx_drive);
      end
      if (h == H_TOTAL - 1) begin
        h = 0;
        v = (v == V_TOTAL - 1) ? 0 : v + 1;
      end else begin
        h++;
      end
      if (h == 0 && v == 0) kx_lat = clamp_x(kx_drive);
    end
  endtask

  task automatic load_table();
    rows[0] = make_row(ACT_IDLE,  1'b0, 0,    1, 1'b0);
    rows[1] = make_row(ACT_START, 1'b0, 20,   2, 1'b0);
    rows[2] = make_row(ACT_IDLE,  1'b1, 0,    2, 1'b1);
    rows[3] = make_row(ACT_IDLE,  1'b0, 1000, 1, 1'b0);
    rows[4] = make_row(ACT_IDLE,  1'b1, 0,    1, 1'b0);
    rows[5] = make_row(ACT_IDLE,  1'b0, 44,   1, 1'b0);
    rows[6] = make_row(ACT_STOP,  1'b1, 0,    2, 1'b0);
    rows[7] = make_row(ACT_START, 1'b1, 0,    2, 1'b1);
    rows[8] = make_row(ACT_IDLE,  1'b0, 0,    1, 1'b0);
  endtask

  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("Timeout: the run hung before all table rows were checked");
    $display("Finished with errors");
    $fatal(1);
  end

  initial begin
    int total_frames;
    clk         = 1'b0;
    rst         = 1'b1;
    start       = 1'b0;
    stop        = 1'b0;
    keeper_x    = '0;
    error_count = 0;
    kx_drive    = 0;
    play_exp    = 1'b0;
    watchdog_ns = 0;
    void'($urandom(20));
    load_table();
    // Each row also spends up to two frames reaching its observed frames.
    total_frames = 2;
    for (int r = 0; r < NUM_ROWS; r++) total_frames += int'(rows[r].frames) + 2;
    watchdog_ns = longint'(total_frames) * FRAME_CYCLES * CLK_PERIOD + 1000;

    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value(vga_out, '0, "vga_out during reset");
    @(posedge clk);
    rst <= 1'b0;

    // The first frame that starts after the press must already be in the new mode.
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(rows[r]);
      wait_frame_start();
      observe(int'(rows[r].frames), rows[r].mid_change);
    end

    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src/draw_field.sv ====
/*
 * Playing field stage.
 * While playing, paints the active area green with a one pixel
 * white goal outline. Otherwise the colour passes through.
 */

`timescale 1ns/1ns

module draw_field import vga_pkg::*; #(
  parameter int H_ACTIVE = 800,
  parameter int V_ACTIVE = 600
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       playing,
  input  vga_pixel_t vin,
  output vga_pixel_t vout
);

  localparam logic [10:0] GOAL_LEFT   = 11'(H_ACTIVE / 4);
  localparam logic [10:0] GOAL_RIGHT  = 11'((3 * H_ACTIVE) / 4);
  localparam logic [10:0] GOAL_TOP    = 11'd1;
  localparam logic [10:0] GOAL_BOTTOM = 11'(V_ACTIVE / 2);

  logic       in_cols;
  logic       in_rows;
  logic       on_goal;
  vga_pixel_t px_nxt;

  assign in_cols = (vin.hcount >= GOAL_LEFT) && (vin.hcount <= GOAL_RIGHT);
  assign in_rows = (vin.vcount >= GOAL_TOP) && (vin.vcount <= GOAL_BOTTOM);

  // Outline only, the goal mouth stays green.
  assign on_goal = (in_cols && ((vin.vcount == GOAL_TOP) || (vin.vcount == GOAL_BOTTOM))) ||
                   (in_rows && ((vin.hcount == GOAL_LEFT) || (vin.hcount == GOAL_RIGHT)));

  always_comb begin
    px_nxt = vin;
    if (vin.hblnk || vin.vblnk) begin
      px_nxt.rgb = '0;
    end else if (playing) begin
      if (on_goal) begin
        px_nxt.rgb = WHITE_START;
      end else begin
        px_nxt.rgb = FIELD_GREEN;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vout <= '0;
    end else begin
      vout <= px_nxt;
    end
  end

endmodule

// ==== src/draw_keeper.sv ====
/*
 * Goalkeeper stage.
 * Draws the keeper box while playing, at a column taken from
 * keeper_x once per frame and clamped to the visible width.
 */

`timescale 1ns/1ns

module draw_keeper import vga_pkg::*; #(
  parameter int H_ACTIVE      = 800,
  parameter int KEEPER_WIDTH  = 80,
  parameter int KEEPER_HEIGHT = 120,
  parameter int KEEPER_Y      = 180
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        playing,
  input  logic [10:0] keeper_x,
  input  vga_pixel_t  vin,
  output vga_pixel_t  vout
);

  localparam logic [10:0] X_MAX  = 11'(H_ACTIVE - KEEPER_WIDTH);
  localparam logic [10:0] Y_TOP  = 11'(KEEPER_Y);
  localparam logic [10:0] Y_END  = 11'(KEEPER_Y + KEEPER_HEIGHT);
  localparam logic [11:0] W_EXT  = 12'(KEEPER_WIDTH);

  logic        frame_start;
  logic [10:0] x_clamped;
  logic [10:0] x_q;
  logic [10:0] x_cur;
  logic        in_box;
  vga_pixel_t  px_nxt;

  assign frame_start = (vin.hcount == 11'd0) && (vin.vcount == 11'd0);
  assign x_clamped   = (keeper_x > X_MAX) ? X_MAX : keeper_x;

  // New position already holds for the first pixel of the frame.
  assign x_cur = frame_start ? x_clamped : x_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= '0;
    end else if (frame_start) begin
      x_q <= x_clamped;
    end
  end

  assign in_box = (vin.hcount >= x_cur) && ({1'b0, vin.hcount} < ({1'b0, x_cur} + W_EXT)) &&
                  (vin.vcount >= Y_TOP) && (vin.vcount < Y_END);

  always_comb begin
    px_nxt = vin;
    if (vin.hblnk || vin.vblnk) begin
      px_nxt.rgb = '0;
    end else if (playing && in_box) begin
      px_nxt.rgb = KEEPER_COLOUR;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vout <= '0;
    end else begin
      vout <= px_nxt;
    end
  end

  // Box never runs past the right edge of the active area.
  keeper_x_clamped: assert property (
    @(posedge clk) disable iff (rst)
    $past(frame_start) |-> (x_q <= X_MAX)
  ) else $error("latched keeper x beyond clamp");

endmodule

// ==== src/draw_screen_start.sv ====
/*
 * Start screen background.
 * Coloured vertical stripes at the top and bottom of the screen
 * and a white band across the middle.
 */

`timescale 1ns/1ns

module draw_screen_start import vga_pkg::*; #(
  parameter int V_ACTIVE         = 600,
  parameter int ST_STRIPE_WIDTH  = 32,
  parameter int ST_STRIPE_HEIGHT = 100
) (
  input  logic       clk,
  input  logic       rst,
  input  vga_pixel_t vin,
  output vga_pixel_t vout
);

  localparam logic [10:0] BAND_TOP    = 11'(ST_STRIPE_HEIGHT);
  localparam logic [10:0] BAND_BOTTOM = 11'(V_ACTIVE - ST_STRIPE_HEIGHT);

  logic [10:0] stripe_idx;
  logic [11:0] stripe_col;
  logic        in_band;
  vga_pixel_t  px_nxt;

  // Stripe number of the current column.
  assign stripe_idx = vin.hcount / 11'(ST_STRIPE_WIDTH);

  always_comb begin
    if (stripe_idx >= 11'd24) begin
      stripe_col = RED_START;
    end else begin
      stripe_col = stripe_rgb(ST_STRIPE_PATTERN[stripe_idx[4:0]]);
    end
  end

  assign in_band = (vin.vcount >= BAND_TOP) && (vin.vcount <= BAND_BOTTOM);

  always_comb begin
    px_nxt = vin;
    if (vin.hblnk || vin.vblnk) begin
      px_nxt.rgb = '0;
    end else if (in_band) begin
      px_nxt.rgb = WHITE_START;
    end else begin
      px_nxt.rgb = stripe_col;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vout <= '0;
    end else begin
      vout <= px_nxt;
    end
  end

endmodule

// ==== src/game_ctl.sv ====
/*
 * Game mode controller.
 * Turns start and stop presses into a playing level that only
 * changes at the first pixel of a frame.
 */

`timescale 1ns/1ns

module game_ctl import vga_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       stop,
  input  vga_pixel_t vin,
  output logic       playing
);

  logic start_q;
  logic stop_q;
  logic start_pend;
  logic stop_pend;
  logic frame_start;

  assign frame_start = (vin.hcount == 11'd0) && (vin.vcount == 11'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      start_q    <= 1'b0;
      stop_q     <= 1'b0;
      start_pend <= 1'b0;
      stop_pend  <= 1'b0;
      playing    <= 1'b0;
    end else begin
      start_q <= start;
      stop_q  <= stop;
      if (frame_start) begin
        // Stop has priority when both requests wait.
        if (stop_pend) begin
          playing <= 1'b0;
        end else if (start_pend) begin
          playing <= 1'b1;
        end
        start_pend <= start & ~start_q;
        stop_pend  <= stop & ~stop_q;
      end else begin
        start_pend <= start_pend | (start & ~start_q);
        stop_pend  <= stop_pend | (stop & ~stop_q);
      end
    end
  end

  // Mode only moves right after the frame start coordinate.
  playing_at_frame_start: assert property (
    @(posedge clk) disable iff (rst)
    $changed(playing) |-> $past(frame_start)
  ) else $error("playing changed in the middle of a frame");

endmodule

// ==== src/vga_game_top.sv ====
/*
 * Penalty-kick display path.
 * Timing generator followed by the start screen, field and keeper
 * stages, with the mode controller watching the raster.
 */

`timescale 1ns/1ns

module vga_game_top import vga_pkg::*; #(
  parameter int H_ACTIVE         = 800,
  parameter int H_TOTAL          = 1056,
  parameter int H_SYNC_START     = 840,
  parameter int H_SYNC_END       = 968,
  parameter int V_ACTIVE         = 600,
  parameter int V_TOTAL          = 628,
  parameter int V_SYNC_START     = 601,
  parameter int V_SYNC_END       = 605,
  parameter int ST_STRIPE_WIDTH  = 32,
  parameter int ST_STRIPE_HEIGHT = 100,
  parameter int KEEPER_WIDTH     = 80,
  parameter int KEEPER_HEIGHT    = 120,
  parameter int KEEPER_Y         = 180
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,
  input  logic        stop,
  input  logic [10:0] keeper_x,
  output vga_pixel_t  vga_out
);

  vga_pixel_t timing_px;
  vga_pixel_t start_px;
  vga_pixel_t field_px;
  logic       playing;

  vga_timing #(
    .H_ACTIVE     (H_ACTIVE),
    .H_TOTAL      (H_TOTAL),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .V_ACTIVE     (V_ACTIVE),
    .V_TOTAL      (V_TOTAL),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END)
  ) vga_timing_inst (
    .clk  (clk),
    .rst  (rst),
    .vout (timing_px)
  );

  game_ctl game_ctl_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .stop    (stop),
    .vin     (timing_px),
    .playing (playing)
  );

  draw_screen_start #(
    .V_ACTIVE         (V_ACTIVE),
    .ST_STRIPE_WIDTH  (ST_STRIPE_WIDTH),
    .ST_STRIPE_HEIGHT (ST_STRIPE_HEIGHT)
  ) draw_screen_start_inst (
    .clk  (clk),
    .rst  (rst),
    .vin  (timing_px),
    .vout (start_px)
  );

  draw_field #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
  ) draw_field_inst (
    .clk     (clk),
    .rst     (rst),
    .playing (playing),
    .vin     (start_px),
    .vout    (field_px)
  );

  draw_keeper #(
    .H_ACTIVE      (H_ACTIVE),
    .KEEPER_WIDTH  (KEEPER_WIDTH),
    .KEEPER_HEIGHT (KEEPER_HEIGHT),
    .KEEPER_Y      (KEEPER_Y)
  ) draw_keeper_inst (
    .clk      (clk),
    .rst      (rst),
    .playing  (playing),
    .keeper_x (keeper_x),
    .vin      (field_px),
    .vout     (vga_out)
  );

endmodule

// ==== src/vga_pkg.sv ====
/*
 * Shared VGA definitions for the penalty-kick display path.
 * Holds the pixel struct passed between drawing stages, the colour
 * constants and the stripe colour table of the start screen.
 */

package vga_pkg;

  // One raster position with its sync, blanking and colour.
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        hblnk;
    logic        vsync;
    logic        vblnk;
    logic [11:0] rgb;
  } vga_pixel_t;

  localparam logic [11:0] YELLOW_START  = 12'hff0;
  localparam logic [11:0] RED_START     = 12'hf00;
  localparam logic [11:0] BLUE_START    = 12'h00f;
  localparam logic [11:0] GREEN_START   = 12'h0f0;
  localparam logic [11:0] BLACK_START   = 12'h000;
  localparam logic [11:0] WHITE_START   = 12'hfff;
  localparam logic [11:0] FIELD_GREEN   = 12'h2a2;
  localparam logic [11:0] KEEPER_COLOUR = 12'hf80;

  // Index into the start screen colours.
  typedef logic [2:0] stripe_colour_t;

  localparam stripe_colour_t SC_YELLOW = 3'd0;
  localparam stripe_colour_t SC_RED    = 3'd1;
  localparam stripe_colour_t SC_BLUE   = 3'd2;
  localparam stripe_colour_t SC_GREEN  = 3'd3;
  localparam stripe_colour_t SC_BLACK  = 3'd4;
  localparam stripe_colour_t SC_WHITE  = 3'd5;

  // Stripes 0 to 23, left to right.
  localparam stripe_colour_t [0:23] ST_STRIPE_PATTERN = '{
    SC_YELLOW, SC_RED,    SC_BLACK, SC_GREEN,  SC_WHITE, SC_RED,    SC_BLUE,   SC_WHITE,
    SC_RED,    SC_YELLOW, SC_BLACK, SC_YELLOW, SC_GREEN, SC_RED,    SC_YELLOW, SC_BLUE,
    SC_BLACK,  SC_WHITE,  SC_GREEN, SC_RED,    SC_BLUE,  SC_YELLOW, SC_WHITE,  SC_GREEN
  };

  function automatic logic [11:0] stripe_rgb(input stripe_colour_t idx);
    logic [11:0] rgb;
    case (idx)
      SC_YELLOW: rgb = YELLOW_START;
      SC_RED:    rgb = RED_START;
      SC_BLUE:   rgb = BLUE_START;
      SC_GREEN:  rgb = GREEN_START;
      SC_BLACK:  rgb = BLACK_START;
      SC_WHITE:  rgb = WHITE_START;
      default:   rgb = RED_START;
    endcase
    return rgb;
  endfunction

endpackage

// ==== src/vga_timing.sv ====
/*
 * VGA timing generator.
 * Free-running horizontal and vertical counters with sync and
 * blanking flags, all active high. Colour is left at zero.
 */

`timescale 1ns/1ns

module vga_timing import vga_pkg::*; #(
  parameter int H_ACTIVE     = 800,
  parameter int H_TOTAL      = 1056,
  parameter int H_SYNC_START = 840,
  parameter int H_SYNC_END   = 968,
  parameter int V_ACTIVE     = 600,
  parameter int V_TOTAL      = 628,
  parameter int V_SYNC_START = 601,
  parameter int V_SYNC_END   = 605
) (
  input  logic       clk,
  input  logic       rst,
  output vga_pixel_t vout
);

  localparam logic [10:0] H_LAST = 11'(H_TOTAL - 1);
  localparam logic [10:0] V_LAST = 11'(V_TOTAL - 1);

  logic [10:0] hcount_nxt;
  logic [10:0] vcount_nxt;
  vga_pixel_t  px_nxt;

  always_comb begin
    hcount_nxt = vout.hcount + 11'd1;
    vcount_nxt = vout.vcount;
    if (vout.hcount == H_LAST) begin
      hcount_nxt = '0;
      if (vout.vcount == V_LAST) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vout.vcount + 11'd1;
      end
    end
  end

  // Flags are derived from the next coordinates so they line up with them.
  always_comb begin
    px_nxt.hcount = hcount_nxt;
    px_nxt.vcount = vcount_nxt;
    px_nxt.hblnk  = (hcount_nxt >= 11'(H_ACTIVE));
    px_nxt.hsync  = (hcount_nxt >= 11'(H_SYNC_START)) && (hcount_nxt < 11'(H_SYNC_END));
    px_nxt.vblnk  = (vcount_nxt >= 11'(V_ACTIVE));
    px_nxt.vsync  = (vcount_nxt >= 11'(V_SYNC_START)) && (vcount_nxt < 11'(V_SYNC_END));
    px_nxt.rgb    = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vout <= '0;
    end else begin
      vout <= px_nxt;
    end
  end

  // The line counter wraps before reaching the line length.
  hcount_in_range: assert property (
    @(posedge clk) disable iff (rst)
    vout.hcount < 11'(H_TOTAL)
  ) else $error("hcount reached H_TOTAL");

endmodule

// ==== tb.f ====
src/vga_pkg.sv
src/vga_timing.sv
src/draw_screen_start.sv
src/game_ctl.sv
src/draw_field.sv
src/draw_keeper.sv
src/vga_game_top.sv
sim/vga_game_tb.sv
